// ==== sim.f ====
+incdir+sim
logic/tagPkg.sv
logic/tagPickIf.sv
logic/laneRanker.sv
logic/freeTagPicker.sv
logic/tagTable.sv
logic/tagAllocator.sv
sim/tagAllocatorTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the tag allocator testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module tagAllocatorTb \
	-Mdir obj_dir -o tagAllocatorSim \
	&& ./obj_dir/tagAllocatorSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation failed."; exit 1; }

cat sim.log

grep -q "TEST RESULT: FAIL" sim.log \
	&& { echo "Simulation reported failure."; exit 1; }

grep -q "TEST RESULT: PASS" sim.log \
	|| { echo "Simulation ended without a result line."; exit 1; }

echo "Simulation passed."
exit 0

// ==== sim/tagModel.svh ====
`ifndef TAG_MODEL_SVH
`define TAG_MODEL_SVH

// Free pool as the testbench sees it. A set bit is a free tag.
tagMaskT modelFree;

// Grants and credit expected after the next rising edge.
laneMaskT expGrantValid;
laneTagsT expGrantTags;
logic expCredit;

function automatic int freeCount(input tagMaskT mask);
	int n;
	n = 0;
	for (int t = 0; t < NUM_TAGS; t++) begin
		if (mask[t]) begin
			n++;
		end
	end
	return n;
endfunction

// Set bit of the given ordinal, counting up from tag 0.
function automatic tagT nthFree(input tagMaskT mask, input int ordinal);
	int seen;
	tagT tag;
	seen = 0;
	tag = '0;
	for (int t = 0; t < NUM_TAGS; t++) begin
		if (mask[t]) begin
			if (seen == ordinal) begin
				tag = tagT'(t);
			end
			seen++;
		end
	end
	return tag;
endfunction

task automatic modelReset();
	modelFree = '1;
	expGrantValid = '0;
	expGrantTags = '0;
	expCredit = 1'b0;
endtask

// One rising edge. Lanes are served in order from the mask before the release lands.
task automatic modelStep(input laneMaskT req, input logic rel, input tagT relTag);
	int rank;
	tagMaskT granted;
	rank = 0;
	granted = '0;
	for (int l = 0; l < NUM_LANES; l++) begin
		if (req[l]) begin
			expGrantTags[l] = nthFree(modelFree, rank);
			granted[expGrantTags[l]] = 1'b1;
			rank++;
		end
	end
	expGrantValid = req;
	expCredit = rel;
	modelFree = modelFree & ~granted;
	if (rel) begin
		modelFree[relTag] = 1'b1;
	end
endtask

`endif

// ==== sim/tagAllocatorTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module tagAllocatorTb;
	import tagPkg::*;

	localparam int RAND_CYCLES = 2000;
	localparam int IDLE_TIMEOUT = 20;

	logic clk;
	logic arstN;
	laneMaskT reqValid;
	logic relValid;
	tagT relTag;
	laneMaskT grantValid;
	laneTagsT grantTag;
	logic creditRet;

	integer seed;
	int credits;
	int grantErrors;
	int creditErrors;
	int poolErrors;
	int timeouts;

	`include "tagModel.svh"

	tagAllocator dut_i (
		.clk_i(clk),
		.arstN_i(arstN),
		.reqValid_i(reqValid),
		.relValid_i(relValid),
		.relTag_i(relTag),
		.grantValid_o(grantValid),
		.grantTag_o(grantTag),
		.creditRet_o(creditRet)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// Tags are compared only on granted lanes.
	task automatic checkGrant(input laneMaskT expValid, input laneTagsT expTags,
		input laneMaskT gotValid, input laneTagsT gotTags);
		if (gotValid !== expValid) begin
			grantErrors++;
			$display("ERR %0t grantValid_o is %b, expected %b", $time, gotValid, expValid);
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			if (expValid[l] && gotTags[l] !== expTags[l]) begin
				grantErrors++;
				$display("ERR %0t lane %0d granted tag %0d, expected %0d",
					$time, l, gotTags[l], expTags[l]);
			end
		end
	endtask

	task automatic checkCredit(input logic exp, input logic got);
		if (got !== exp) begin
			creditErrors++;
			$display("ERR %0t creditRet_o is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic checkPool(input int expFree, input int gotCredits);
		if (gotCredits != expFree) begin
			poolErrors++;
			$display("ERR %0t producer holds %0d credits, model has %0d free tags",
				$time, gotCredits, expFree);
		end
	endtask

	// Called on a falling edge.
	task automatic applyInputs(input laneMaskT req, input logic rel, input tagT tag);
		reqValid = req;
		relValid = rel;
		relTag = tag;
		credits = credits - $countones(req);
		modelStep(req, rel, tag);
	endtask

	task automatic advanceCycle();
		@(posedge clk);
		@(negedge clk);
		checkGrant(expGrantValid, expGrantTags, grantValid, grantTag);
		checkCredit(expCredit, creditRet);
		if (creditRet === 1'b1) begin
			credits++;
		end
		checkPool(freeCount(modelFree), credits);
	endtask

	task automatic step(input laneMaskT req, input logic rel, input tagT tag);
		applyInputs(req, rel, tag);
		advanceCycle();
	endtask

	task automatic waitIdle();
		int cycles;
		cycles = 0;
		while ((grantValid !== '0 || creditRet !== 1'b0) && cycles < IDLE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (grantValid !== '0 || creditRet !== 1'b0) begin
			timeouts++;
			$display("Timeout: the outputs did not go idle after reset.");
		end
	endtask

	// Random tag among those that the model shows as allocated.
	function automatic tagT randomAllocated(input int r);
		int nAlloc;
		nAlloc = NUM_TAGS - freeCount(modelFree);
		return nthFree(~modelFree, (r & 32'h7fffffff) % nAlloc);
	endfunction

	initial begin
		laneTagsT burst;
		laneMaskT req;
		logic rel;
		tagT tag;
		arstN = 1'b0;
		reqValid = '0;
		relValid = 1'b0;
		relTag = '0;
		seed = 32'hcd9d98bf;
		credits = NUM_TAGS;
		grantErrors = 0;
		creditErrors = 0;
		poolErrors = 0;
		timeouts = 0;
		modelReset();

		repeat (3) begin
			@(negedge clk);
			checkGrant('0, '0, grantValid, grantTag);
			checkCredit(1'b0, creditRet);
		end
		arstN = 1'b1;
		waitIdle();

		// Full burst takes tags 0 to 15 in lane order.
		for (int c = 0; c < NUM_TAGS / NUM_LANES; c++) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				burst[l] = tagT'(NUM_LANES * c + l);
			end
			step('1, 1'b0, '0);
			checkGrant('1, burst, grantValid, grantTag);
		end

		// Released tag returns a credit and is the only one to grant.
		step('0, 1'b1, tagT'(5));
		step('0, 1'b0, '0);
		step(4'b0100, 1'b0, '0);
		burst[2] = tagT'(5);
		checkGrant(4'b0100, burst, grantValid, grantTag);

		// Tag 3 comes back in the same cycle as a request and must wait.
		step('0, 1'b1, tagT'(9));
		step(4'b0001, 1'b1, tagT'(3));
		burst[0] = tagT'(9);
		checkGrant(4'b0001, burst, grantValid, grantTag);
		step(4'b1000, 1'b0, '0);
		burst[3] = tagT'(3);
		checkGrant(4'b1000, burst, grantValid, grantTag);

		for (int i = 0; i < RAND_CYCLES; i++) begin
			req = laneMaskT'($random(seed));
			// Drop the top lanes until the request fits the credits.
			for (int l = NUM_LANES - 1; l >= 0; l--) begin
				if (req[l] && $countones(req) > credits) begin
					req[l] = 1'b0;
				end
			end
			rel = 1'b0;
			tag = '0;
			if (freeCount(modelFree) < NUM_TAGS && ($random(seed) & 1) != 0) begin
				rel = 1'b1;
				tag = randomAllocated($random(seed));
			end
			step(req, rel, tag);
		end
		step('0, 1'b0, '0);

		$display("Errors: grant %0d, credit %0d, pool %0d, timeout %0d",
			grantErrors, creditErrors, poolErrors, timeouts);
		if (grantErrors + creditErrors + poolErrors + timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/tagAllocator.sv ====
`timescale 1ns/10ps
`default_nettype none

module tagAllocator (
	input logic clk_i,
	input logic arstN_i,
	input tagPkg::laneMaskT reqValid_i,
	input logic relValid_i,
	input tagPkg::tagT relTag_i,
	output tagPkg::laneMaskT grantValid_o,
	output tagPkg::laneTagsT grantTag_o,
	output logic creditRet_o
);
	import tagPkg::*;

	laneRanksT laneRanks;
	cntT reqCount;

	// Free mask and picks between the table and the picker.
	tagPickIf pickIf ();

	laneRanker ranker_i (
		.reqValid_i(reqValid_i),
		.laneRanks_o(laneRanks),
		.reqCount_o(reqCount)
	);

	freeTagPicker picker_i (
		.pick_i(pickIf.picker)
	);

	tagTable table_i (
		.clk_i(clk_i),
		.arstN_i(arstN_i),
		.reqValid_i(reqValid_i),
		.laneRanks_i(laneRanks),
		.reqCount_i(reqCount),
		.relValid_i(relValid_i),
		.relTag_i(relTag_i),
		.pick_i(pickIf.tableSide),
		.grantValid_o(grantValid_o),
		.grantTag_o(grantTag_o),
		.creditRet_o(creditRet_o)
	);

endmodule

`default_nettype wire

// ==== logic/tagTable.sv ====
`timescale 1ns/10ps
`default_nettype none

module tagTable (
	input logic clk_i,
	input logic arstN_i,
	input tagPkg::laneMaskT reqValid_i,
	input tagPkg::laneRanksT laneRanks_i,
	input tagPkg::cntT reqCount_i,
	input logic relValid_i,
	input tagPkg::tagT relTag_i,
	tagPickIf.tableSide pick_i,
	output tagPkg::laneMaskT grantValid_o,
	output tagPkg::laneTagsT grantTag_o,
	output logic creditRet_o
);
	import tagPkg::*;

	tagMaskT freeQ;
	tagMaskT freeNext;
	tagMaskT clrMask;
	tagMaskT setMask;
	laneTagsT laneTags;

	assign pick_i.freeMask = freeQ;

	// Each lane takes the pick whose ordinal equals its rank.
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			laneTags[l] = pick_i.pickTags[laneRanks_i[l]];
		end
	end

	// Tags granted this cycle leave the pool.
	always_comb begin
		clrMask = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (reqValid_i[l]) begin
				clrMask[laneTags[l]] = 1'b1;
			end
		end
	end

	always_comb begin
		setMask = '0;
		if (relValid_i) begin
			setMask[relTag_i] = 1'b1;
		end
	end

	// A released tag is allocated, so it never collides with a grant.
	assign freeNext = (freeQ & ~clrMask) | setMask;

	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			freeQ <= '1;
			grantValid_o <= '0;
			creditRet_o <= 1'b0;
		end else begin
			freeQ <= freeNext;
			grantValid_o <= reqValid_i;
			creditRet_o <= relValid_i;
		end
	end

	// Tag payload only loads on lanes that are granted.
	always_ff @(posedge clk_i) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			if (reqValid_i[l]) begin
				grantTag_o[l] <= laneTags[l];
			end
		end
	end

	// Credit flow control keeps requests within the free pool.
	property pReqWithinFree;
		@(posedge clk_i) disable iff (!arstN_i)
			reqCount_i <= cntT'($countones(pick_i.pickValid));
	endproperty
	aReqWithinFree: assert property (pReqWithinFree)
		else $error("request count %0d exceeds free tags", reqCount_i);

	// Only an allocated tag may come back.
	property pRelAllocated;
		@(posedge clk_i) disable iff (!arstN_i)
			relValid_i |-> !freeQ[relTag_i];
	endproperty
	aRelAllocated: assert property (pRelAllocated)
		else $error("release of free tag %0d", relTag_i);

endmodule

`default_nettype wire

// ==== logic/freeTagPicker.sv ====
`timescale 1ns/10ps
`default_nettype none

module freeTagPicker (
	tagPickIf.picker pick_i
);
	import tagPkg::*;

	// Lowest set bit of a nibble; all zero gives 3.
	function automatic logic [1:0] lowFirst4(input logic [3:0] bits);
		logic [1:0] idx;
		if (bits[0])
			idx = 2'd0;
		else if (bits[1])
			idx = 2'd1;
		else if (bits[2])
			idx = 2'd2;
		else
			idx = 2'd3;
		return idx;
	endfunction

	// Two level search: first the lowest nibble with a free bit, then inside it.
	function automatic tagT lowFirst16(input tagMaskT mask);
		logic [3:0] nibAny;
		logic [1:0] nibSel;
		logic [3:0] nib;
		for (int n = 0; n < 4; n++) begin
			nibAny[n] = |mask[4*n +: 4];
		end
		nibSel = lowFirst4(nibAny);
		nib = mask[{nibSel, 2'b00} +: 4];
		return {nibSel, lowFirst4(nib)};
	endfunction

	function automatic logic [3:0] decode4(input logic [1:0] sel);
		logic [3:0] hot;
		case (sel)
			2'd0: hot = 4'b0001;
			2'd1: hot = 4'b0010;
			2'd2: hot = 4'b0100;
			default: hot = 4'b1000;
		endcase
		return hot;
	endfunction

	// One-hot decode of a tag, built from two 2-to-4 decodes.
	function automatic tagMaskT decode16(input tagT tag);
		logic [3:0] hiHot;
		logic [3:0] loHot;
		tagMaskT hot;
		hiHot = decode4(tag[3:2]);
		loHot = decode4(tag[1:0]);
		for (int n = 0; n < 4; n++) begin
			hot[4*n +: 4] = loHot & {4{hiHot[n]}};
		end
		return hot;
	endfunction

	// Mask left over in front of each search stage.
	tagMaskT stageMask [NUM_LANES];
	tagT stageTag [NUM_LANES];

	always_comb begin
		stageMask[0] = pick_i.freeMask;
		for (int k = 0; k < NUM_LANES; k++) begin
			stageTag[k] = lowFirst16(stageMask[k]);
			if (k < NUM_LANES - 1) begin
				// Clear the tag just found before the next search.
				stageMask[k+1] = stageMask[k] & ~decode16(stageTag[k]);
			end
		end
	end

	// An empty stage mask means the pool ran out before this ordinal.
	always_comb begin
		for (int k = 0; k < NUM_LANES; k++) begin
			pick_i.pickTags[k] = stageTag[k];
			pick_i.pickValid[k] = |stageMask[k];
		end
	end

endmodule

`default_nettype wire

// ==== logic/laneRanker.sv ====
`timescale 1ns/10ps
`default_nettype none

module laneRanker (
	input tagPkg::laneMaskT reqValid_i,
	output tagPkg::laneRanksT laneRanks_o,
	output tagPkg::cntT reqCount_o
);
	import tagPkg::*;

	// Number of requesting lanes strictly below the given lane.
	function automatic cntT countBelow(input laneMaskT valid, input int lane);
		cntT cnt;
		cnt = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (l < lane && valid[l]) begin
				cnt = cnt + cntT'(1);
			end
		end
		return cnt;
	endfunction

	cntT belowCnt [NUM_LANES];

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			belowCnt[l] = countBelow(reqValid_i, l);
		end
	end

	// A lane never has more than NUM_LANES-1 lanes below it, so the rank fits.
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			laneRanks_o[l] = belowCnt[l][RANK_W-1:0];
		end
	end

	// Total is the count below the top lane plus the top lane itself.
	always_comb begin
		reqCount_o = belowCnt[NUM_LANES-1] + cntT'(reqValid_i[NUM_LANES-1]);
	end

endmodule

`default_nettype wire

// ==== logic/tagPickIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface tagPickIf;
	import tagPkg::*;

	// Registered free mask, owned by the table.
	tagMaskT freeMask;

	// Lowest free tags, entry k holds the free tag of ordinal k.
	laneTagsT pickTags;

	// Bit k is set when at least k+1 tags are free.
	laneMaskT pickValid;

	modport tableSide (
		output freeMask,
		input pickTags,
		input pickValid
	);

	modport picker (
		input freeMask,
		output pickTags,
		output pickValid
	);

endinterface

`default_nettype wire

// ==== logic/tagPkg.sv ====
`default_nettype none

package tagPkg;

	// Pool and lane sizes.
	localparam int NUM_TAGS = 16;
	localparam int TAG_W = 4;
	localparam int NUM_LANES = 4;

	// A rank is the position of a lane among the requesting lanes.
	localparam int RANK_W = 2;

	// Counts run from 0 to NUM_LANES.
	localparam int CNT_W = 3;

	typedef logic [TAG_W-1:0] tagT;

	// A set bit marks a free tag.
	typedef logic [NUM_TAGS-1:0] tagMaskT;

	typedef logic [NUM_LANES-1:0] laneMaskT;

	typedef tagT [NUM_LANES-1:0] laneTagsT;

	typedef logic [NUM_LANES-1:0][RANK_W-1:0] laneRanksT;

	typedef logic [CNT_W-1:0] cntT;

endpackage

`default_nettype wire
